//--- dv/rx_async_capture_tb.sv
////////////////////
// Both words are compared every cycle against a model that moves only on load strobes
////////////////////
`timescale 1ns/10ps

module rx_async_capture_tb;

  import rx_async_capture_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;
  // Slow-word position of each single-bit input, in sbits order
  localparam int SBIT_POS [20] = '{
    SSR_A1A2_BIT, SSR_BITLOC_REV_BIT, SSR_BYTE_REV_BIT, SSR_ENCDT_BIT,
    SSR_KRFEC_CLR_BIT, SSR_BER_CLR_BIT, SSR_ADAPT_START_BIT, SSR_EARLY_EIOS_BIT,
    SSR_PPM_LOCK_BIT, SSR_RS_LPBK_BIT, SSR_RXCLKSLIP_BIT, SSR_BITSLIP_BIT,
    SSR_POLINV_BIT, SSR_PRBS_CLR_BIT, SSR_SYNCSM_EN_BIT, SSR_LAT_ADJ_BIT,
    SSR_DLL_LOCK_BIT, SSR_DLL_LOCK_REQ_BIT, SSR_TRANSFER_EN_BIT, SSR_DCD_CAL_REQ_BIT
  };

  logic           clk = 1'b0;
  logic           rst;
  logic           fsr_load;
  logic           ssr_load;
  fsr_data_t      fsr_rst_val;
  logic [3:0]     bypass;
  fsr_data_t      fsr_in;
  logic [19:0]    sbits;
  eidleinfersel_t eidle;
  eye_monitor_t   eye;
  pcie_switch_t   pcie;
  reserved_out_t  resv;
  fsr_data_t      fsr_data;
  ssr_data_t      ssr_data;

  ssr_data_t      ssr_ref;
  fsr_data_t      fsr_ref;
  ssr_data_t      exp_ssr;
  fsr_data_t      exp_fsr;
  int             cycle_cnt = 0;
  logic [31:0]    rng_state = 32'd922;
  eye_monitor_t   eye_stable;

  always #5 clk = ~clk;

  rx_async_capture #(
    .SYNC_LONG_STAGES  (SYNC_LONG),
    .SYNC_SHORT_STAGES (SYNC_SHORT)
  ) rx_async_capture_inst (
    .rx_clock_async_tx_osc_clk       (clk),
    .rst                             (rst),
    .fsr_load                        (fsr_load),
    .ssr_load                        (ssr_load),
    .fsr_rst_val                     (fsr_rst_val),
    .eidleinfersel_bypass            (bypass[0]),
    .eye_monitor_bypass              (bypass[1]),
    .pcie_switch_bypass              (bypass[2]),
    .reserved_out_bypass             (bypass[3]),
    .pld_ltr                         (fsr_in[0]),
    .pld_pma_ltd_b                   (fsr_in[1]),
    .pld_rx_fabric_fifo_align_clr    (fsr_in[2]),
    .pld_8g_a1a2_size                (sbits[0]),
    .pld_8g_bitloc_rev_en            (sbits[1]),
    .pld_8g_byte_rev_en              (sbits[2]),
    .pld_8g_eidleinfersel            (eidle),
    .pld_8g_encdt                    (sbits[3]),
    .pld_10g_krfec_rx_clr_errblk_cnt (sbits[4]),
    .pld_10g_rx_clr_ber_count        (sbits[5]),
    .pld_pma_adapt_start             (sbits[6]),
    .pld_pma_early_eios              (sbits[7]),
    .pld_pma_eye_monitor             (eye),
    .pld_pma_pcie_switch             (pcie),
    .pld_pma_ppm_lock                (sbits[8]),
    .pld_pma_reserved_out            (resv),
    .pld_pma_rs_lpbk_b               (sbits[9]),
    .pld_pmaif_rxclkslip             (sbits[10]),
    .pld_bitslip                     (sbits[11]),
    .pld_polinv_rx                   (sbits[12]),
    .pld_rx_prbs_err_clr             (sbits[13]),
    .pld_syncsm_en                   (sbits[14]),
    .pld_rx_fifo_latency_adj_en      (sbits[15]),
    .rx_hrdrst_fabric_rx_dll_lock    (sbits[16]),
    .pld_rx_dll_lock_req             (sbits[17]),
    .rx_hrdrst_fabric_rx_transfer_en (sbits[18]),
    .pld_aib_hssi_rx_dcd_cal_req     (sbits[19]),
    .fsr_data                        (fsr_data),
    .ssr_data                        (ssr_data)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic ssr_data_t expected_ssr(input logic [19:0] bits, input eidleinfersel_t ei,
                                             input eye_monitor_t em, input pcie_switch_t ps,
                                             input reserved_out_t ro);
    ssr_data_t w;
    w = '0;
    for (int i = 0; i < 20; i++) begin
      w[SBIT_POS[i]] = bits[i];
    end
    w[SSR_EIDLEINFERSEL_LSB +: $bits(eidleinfersel_t)] = ei;
    w[SSR_EYE_MONITOR_LSB +: $bits(eye_monitor_t)]     = em;
    w[SSR_PCIE_SWITCH_LSB +: $bits(pcie_switch_t)]     = ps;
    w[SSR_RESERVED_LSB +: $bits(reserved_out_t)]       = ro;
    return w;
  endfunction

  function automatic fsr_data_t expected_fsr(input logic ltr, input logic ltd_b,
                                             input logic align_clr);
    return {align_clr, ltd_b, ltr};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic drive_random_inputs();
    logic [31:0] r0;
    logic [31:0] r1;
    rng_state = lcg_next(rng_state);
    r0 = rng_state;
    rng_state = lcg_next(rng_state);
    r1 = rng_state;
    sbits  <= r0[31:12];
    fsr_in <= r0[11:9];
    eidle  <= r1[31:29];
    eye    <= r1[28:23];
    pcie   <= r1[22:21];
    resv   <= r1[20:16];
    bypass <= r1[15:12];
  endtask

  task automatic run_reset(input fsr_data_t val);
    @(posedge clk);
    rst         <= 1'b1;
    fsr_rst_val <= val;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic load_slow(input ssr_data_t expected);
    ssr_ref  <= expected;
    ssr_load <= 1'b1;
    @(posedge clk);
    ssr_load <= 1'b0;
  endtask

  task automatic load_fast(input fsr_data_t expected);
    fsr_ref  <= expected;
    fsr_load <= 1'b1;
    @(posedge clk);
    fsr_load <= 1'b0;
  endtask

  // Expected words follow the strobe the DUT samples at the same edge
  always @(posedge clk) begin
    if (rst) begin
      exp_ssr <= SSR_RESET_VAL;
      exp_fsr <= fsr_rst_val;
    end else begin
      if (ssr_load) begin
        exp_ssr <= ssr_ref;
      end
      if (fsr_load) begin
        exp_fsr <= fsr_ref;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      check_value("ssr_data", ssr_data, exp_ssr);
      check_value("fsr_data", fsr_data, exp_fsr);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst         = 1'b1;
    fsr_load    = 1'b0;
    ssr_load    = 1'b0;
    fsr_rst_val = 3'b101;
    bypass      = '0;
    fsr_in      = '0;
    sbits       = '0;
    eidle       = '0;
    eye         = '0;
    pcie        = '0;
    resv        = '0;
    ssr_ref     = SSR_RESET_VAL;
    fsr_ref     = '0;

    // Reset words before any load, for both reset-copy selections
    run_reset(3'b101);
    repeat (6) @(posedge clk);
    run_reset(3'b010);
    repeat (6) @(posedge clk);

    repeat (40) begin
      @(posedge clk);
      drive_random_inputs();
      repeat (10) @(posedge clk);
      load_slow(expected_ssr(sbits, eidle, eye, pcie, resv));
    end

    repeat (20) begin
      @(posedge clk);
      drive_random_inputs();
      repeat (10) @(posedge clk);
      load_fast(expected_fsr(fsr_in[0], fsr_in[1], fsr_in[2]));
    end

    // Inputs move with no strobe and the words hold
    @(posedge clk);
    drive_random_inputs();
    repeat (10) @(posedge clk);

    // Polling on, then eye_monitor toggles through a load
    @(posedge clk);
    drive_random_inputs();
    bypass <= '0;
    repeat (10) @(posedge clk);
    eye_stable = eye;
    load_slow(expected_ssr(sbits, eidle, eye_stable, pcie, resv));
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      eye <= (i % 2 == 0) ? ~eye_stable : eye_stable ^ 6'h15;
      if (i == 8) begin
        ssr_ref  <= expected_ssr(sbits, eidle, eye_stable, pcie, resv);
        ssr_load <= 1'b1;
      end else begin
        ssr_load <= 1'b0;
      end
    end
    repeat (4) @(posedge clk);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- rx_async_capture.f
verilog/rx_async_capture_pkg.sv
verilog/async_sync_chain.sv
verilog/capture_bus_poll.sv
verilog/fsr_capture.sv
verilog/ssr_capture.sv
verilog/rx_async_capture.sv
dv/rx_async_capture_tb.sv

//--- verilog/async_sync_chain.sv
////////////////////
// data_in has no timing relation to clk; STAGES of 2 or more
////////////////////
`timescale 1ns/10ps

module async_sync_chain #(
  parameter int               WIDTH     = 1,
  parameter int               STAGES    = 2,
  parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stage_q [STAGES];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= RESET_VAL;
      end
    end else begin
      stage_q[0] <= data_in;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_out = stage_q[STAGES-1];

  // A single flop gives no metastability settling time
  a_min_stages: assert property (@(posedge clk) STAGES >= 2);

endmodule

//--- verilog/capture_bus_poll.sv
////////////////////
// sync_in must already be in the clk domain
// bypass is a static configuration level
////////////////////
`timescale 1ns/10ps

module capture_bus_poll #(
  parameter int               WIDTH     = 1,
  parameter logic [WIDTH-1:0] RESET_VAL = '1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] sync_in,
  input  logic             bypass,
  input  logic             load,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] prev_q;
  logic [WIDTH-1:0] stable_q;
  logic             match;

  // Two back-to-back samples agree, so the bus is not mid-transition
  assign match = (sync_in == prev_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_q   <= RESET_VAL;
      stable_q <= RESET_VAL;
      data_out <= RESET_VAL;
    end else begin
      prev_q <= sync_in;
      if (match) begin
        stable_q <= sync_in;
      end
      if (load) begin
        data_out <= bypass ? sync_in : stable_q;
      end
    end
  end

  a_stable_after_match: assert property (
    @(posedge clk) disable iff (rst)
    !bypass && !$past(rst) && $changed(stable_q) |-> $past(match)
  );

  // Scan chain sees a new value only after its own strobe
  a_out_after_load: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) && $changed(data_out) |-> $past(load)
  );

endmodule

//--- verilog/fsr_capture.sv
////////////////////
// rst_val picks per bit which reset copy is shown before the first load
////////////////////
`timescale 1ns/10ps

module fsr_capture #(
  parameter int LONG_STAGES  = rx_async_capture_pkg::SYNC_LONG,
  parameter int SHORT_STAGES = rx_async_capture_pkg::SYNC_SHORT
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            ltr,
  input  logic                            pma_ltd_b,
  input  logic                            fifo_align_clr,
  input  logic                            load,
  input  rx_async_capture_pkg::fsr_data_t rst_val,
  output rx_async_capture_pkg::fsr_data_t fsr_data
);

  import rx_async_capture_pkg::*;

  fsr_data_t raw;
  fsr_data_t sync1;
  fsr_data_t sync0;
  fsr_data_t cap1_q;
  fsr_data_t cap0_q;

  assign raw = {fifo_align_clr, pma_ltd_b, ltr};

  for (genvar i = 0; i < FSR_W; i++) begin : g_bit
    // FIFO align clear uses the shallow chain
    localparam int DEPTH = (i == 2) ? SHORT_STAGES : LONG_STAGES;

    async_sync_chain #(
      .WIDTH     (1),
      .STAGES    (DEPTH),
      .RESET_VAL (1'b1)
    ) sync_rst1_inst (
      .clk      (clk),
      .rst      (rst),
      .data_in  (raw[i]),
      .data_out (sync1[i])
    );

    async_sync_chain #(
      .WIDTH     (1),
      .STAGES    (DEPTH),
      .RESET_VAL (1'b0)
    ) sync_rst0_inst (
      .clk      (clk),
      .rst      (rst),
      .data_in  (raw[i]),
      .data_out (sync0[i])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cap1_q <= '1;
      cap0_q <= '0;
    end else if (load) begin
      cap1_q <= sync1;
      cap0_q <= sync0;
    end
  end

  assign fsr_data = (rst_val & cap1_q) | (~rst_val & cap0_q);

  a_capture_on_load: assert property (
    @(posedge clk) $changed({cap1_q, cap0_q}) |-> $past(load || rst)
  );

endmodule

//--- verilog/rx_async_capture.sv
////////////////////
// Fabric inputs are asynchronous; fsr_load and ssr_load are
// single-cycle strobes in the oscillator clock domain
////////////////////
`timescale 1ns/10ps

module rx_async_capture #(
  parameter int SYNC_LONG_STAGES  = rx_async_capture_pkg::SYNC_LONG,
  parameter int SYNC_SHORT_STAGES = rx_async_capture_pkg::SYNC_SHORT
) (
  input  logic                                rx_clock_async_tx_osc_clk,
  input  logic                                rst,
  input  logic                                fsr_load,
  input  logic                                ssr_load,
  input  rx_async_capture_pkg::fsr_data_t     fsr_rst_val,
  input  logic                                eidleinfersel_bypass,
  input  logic                                eye_monitor_bypass,
  input  logic                                pcie_switch_bypass,
  input  logic                                reserved_out_bypass,
  // Fast word sources
  input  logic                                pld_ltr,
  input  logic                                pld_pma_ltd_b,
  input  logic                                pld_rx_fabric_fifo_align_clr,
  // Slow word sources
  input  logic                                pld_8g_a1a2_size,
  input  logic                                pld_8g_bitloc_rev_en,
  input  logic                                pld_8g_byte_rev_en,
  input  rx_async_capture_pkg::eidleinfersel_t pld_8g_eidleinfersel,
  input  logic                                pld_8g_encdt,
  input  logic                                pld_10g_krfec_rx_clr_errblk_cnt,
  input  logic                                pld_10g_rx_clr_ber_count,
  input  logic                                pld_pma_adapt_start,
  input  logic                                pld_pma_early_eios,
  input  rx_async_capture_pkg::eye_monitor_t  pld_pma_eye_monitor,
  input  rx_async_capture_pkg::pcie_switch_t  pld_pma_pcie_switch,
  input  logic                                pld_pma_ppm_lock,
  input  rx_async_capture_pkg::reserved_out_t pld_pma_reserved_out,
  input  logic                                pld_pma_rs_lpbk_b,
  input  logic                                pld_pmaif_rxclkslip,
  input  logic                                pld_bitslip,
  input  logic                                pld_polinv_rx,
  input  logic                                pld_rx_prbs_err_clr,
  input  logic                                pld_syncsm_en,
  input  logic                                pld_rx_fifo_latency_adj_en,
  input  logic                                rx_hrdrst_fabric_rx_dll_lock,
  input  logic                                pld_rx_dll_lock_req,
  input  logic                                rx_hrdrst_fabric_rx_transfer_en,
  input  logic                                pld_aib_hssi_rx_dcd_cal_req,
  output rx_async_capture_pkg::fsr_data_t     fsr_data,
  output rx_async_capture_pkg::ssr_data_t     ssr_data
);

  fsr_capture #(
    .LONG_STAGES  (SYNC_LONG_STAGES),
    .SHORT_STAGES (SYNC_SHORT_STAGES)
  ) fsr_capture_inst (
    .clk            (rx_clock_async_tx_osc_clk),
    .rst            (rst),
    .ltr            (pld_ltr),
    .pma_ltd_b      (pld_pma_ltd_b),
    .fifo_align_clr (pld_rx_fabric_fifo_align_clr),
    .load           (fsr_load),
    .rst_val        (fsr_rst_val),
    .fsr_data       (fsr_data)
  );

  // Slow-path port names match the top level one for one
  ssr_capture #(
    .LONG_STAGES  (SYNC_LONG_STAGES),
    .SHORT_STAGES (SYNC_SHORT_STAGES)
  ) ssr_capture_inst (
    .clk  (rx_clock_async_tx_osc_clk),
    .load (ssr_load),
    .*
  );

endmodule

//--- verilog/rx_async_capture_pkg.sv
////////////////////
// Slow word layout follows the transceiver scan-chain bit order
// Bits 32 to 35 leave reset low, all other slow bits high
////////////////////
package rx_async_capture_pkg;

  localparam int FSR_W = 3;
  localparam int SSR_W = 36;

  // Synchronizer depths
  localparam int SYNC_LONG  = 4;
  localparam int SYNC_SHORT = 2;

  typedef logic [FSR_W-1:0] fsr_data_t;
  typedef logic [SSR_W-1:0] ssr_data_t;

  typedef logic [2:0] eidleinfersel_t;
  typedef logic [5:0] eye_monitor_t;
  typedef logic [1:0] pcie_switch_t;
  typedef logic [4:0] reserved_out_t;

  // Slow word bit positions
  localparam int SSR_A1A2_BIT          = 0;
  localparam int SSR_BITLOC_REV_BIT    = 1;
  localparam int SSR_BYTE_REV_BIT      = 2;
  localparam int SSR_EIDLEINFERSEL_LSB = 3;
  localparam int SSR_ENCDT_BIT         = 6;
  localparam int SSR_KRFEC_CLR_BIT     = 7;
  localparam int SSR_BER_CLR_BIT       = 8;
  localparam int SSR_ADAPT_START_BIT   = 9;
  localparam int SSR_EARLY_EIOS_BIT    = 10;
  localparam int SSR_EYE_MONITOR_LSB   = 11;
  localparam int SSR_PCIE_SWITCH_LSB   = 17;
  localparam int SSR_PPM_LOCK_BIT      = 19;
  localparam int SSR_RESERVED_LSB      = 20;
  localparam int SSR_RS_LPBK_BIT       = 25;
  localparam int SSR_RXCLKSLIP_BIT     = 26;
  localparam int SSR_BITSLIP_BIT       = 27;
  localparam int SSR_POLINV_BIT        = 28;
  localparam int SSR_PRBS_CLR_BIT      = 29;
  localparam int SSR_SYNCSM_EN_BIT     = 30;
  localparam int SSR_LAT_ADJ_BIT       = 31;
  localparam int SSR_DLL_LOCK_BIT      = 32;
  localparam int SSR_DLL_LOCK_REQ_BIT  = 33;
  localparam int SSR_TRANSFER_EN_BIT   = 34;
  localparam int SSR_DCD_CAL_REQ_BIT   = 35;

  // Reset-controller handshakes come up low
  localparam ssr_data_t SSR_RESET_VAL = {4'b0000, 32'hffff_ffff};

endpackage

//--- verilog/ssr_capture.sv
////////////////////
// Multi-bit fields are polled unless their bypass bit is set
////////////////////
`timescale 1ns/10ps

module ssr_capture #(
  parameter int LONG_STAGES  = rx_async_capture_pkg::SYNC_LONG,
  parameter int SHORT_STAGES = rx_async_capture_pkg::SYNC_SHORT
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                load,
  input  logic                                pld_8g_a1a2_size,
  input  logic                                pld_8g_bitloc_rev_en,
  input  logic                                pld_8g_byte_rev_en,
  input  rx_async_capture_pkg::eidleinfersel_t pld_8g_eidleinfersel,
  input  logic                                pld_8g_encdt,
  input  logic                                pld_10g_krfec_rx_clr_errblk_cnt,
  input  logic                                pld_10g_rx_clr_ber_count,
  input  logic                                pld_pma_adapt_start,
  input  logic                                pld_pma_early_eios,
  input  rx_async_capture_pkg::eye_monitor_t  pld_pma_eye_monitor,
  input  rx_async_capture_pkg::pcie_switch_t  pld_pma_pcie_switch,
  input  logic                                pld_pma_ppm_lock,
  input  rx_async_capture_pkg::reserved_out_t pld_pma_reserved_out,
  input  logic                                pld_pma_rs_lpbk_b,
  input  logic                                pld_pmaif_rxclkslip,
  input  logic                                pld_bitslip,
  input  logic                                pld_polinv_rx,
  input  logic                                pld_rx_prbs_err_clr,
  input  logic                                pld_syncsm_en,
  input  logic                                pld_rx_fifo_latency_adj_en,
  input  logic                                rx_hrdrst_fabric_rx_dll_lock,
  input  logic                                pld_rx_dll_lock_req,
  input  logic                                rx_hrdrst_fabric_rx_transfer_en,
  input  logic                                pld_aib_hssi_rx_dcd_cal_req,
  input  logic                                eidleinfersel_bypass,
  input  logic                                eye_monitor_bypass,
  input  logic                                pcie_switch_bypass,
  input  logic                                reserved_out_bypass,
  output rx_async_capture_pkg::ssr_data_t     ssr_data
);

  import rx_async_capture_pkg::*;

  localparam int SHORT_N = 11;
  localparam int LONG_N  = 9;
  localparam int BUS_N   = $bits(eidleinfersel_t) + $bits(eye_monitor_t) +
                           $bits(pcie_switch_t) + $bits(reserved_out_t);
  // Top four long-chain bits are reset-controller handshakes
  localparam logic [LONG_N-1:0] LONG_RST = 9'b0_0001_1111;
  // Bus slices packed as eidleinfersel, eye_monitor, pcie_switch, reserved
  localparam int BUS_LSB [4] = '{0, 3, 9, 11};
  localparam int BUS_W   [4] = '{3, 6, 2, 5};

  logic [SHORT_N-1:0] short_raw;
  logic [SHORT_N-1:0] short_sync;
  logic [SHORT_N-1:0] short_q;
  logic [LONG_N-1:0]  long_raw;
  logic [LONG_N-1:0]  long_sync;
  logic [LONG_N-1:0]  long_q;
  logic [BUS_N-1:0]   bus_raw;
  logic [BUS_N-1:0]   bus_sync;
  logic [BUS_N-1:0]   bus_q;
  logic [3:0]         bus_bypass;

  assign short_raw = {pld_rx_fifo_latency_adj_en, pld_syncsm_en, pld_rx_prbs_err_clr,
                      pld_polinv_rx, pld_bitslip, pld_10g_rx_clr_ber_count,
                      pld_10g_krfec_rx_clr_errblk_cnt, pld_8g_encdt, pld_8g_byte_rev_en,
                      pld_8g_bitloc_rev_en, pld_8g_a1a2_size};
  assign long_raw  = {pld_aib_hssi_rx_dcd_cal_req, rx_hrdrst_fabric_rx_transfer_en,
                      pld_rx_dll_lock_req, rx_hrdrst_fabric_rx_dll_lock, pld_pmaif_rxclkslip,
                      pld_pma_rs_lpbk_b, pld_pma_ppm_lock, pld_pma_early_eios,
                      pld_pma_adapt_start};
  assign bus_raw   = {pld_pma_reserved_out, pld_pma_pcie_switch, pld_pma_eye_monitor,
                      pld_8g_eidleinfersel};
  assign bus_bypass = {reserved_out_bypass, pcie_switch_bypass, eye_monitor_bypass,
                       eidleinfersel_bypass};

  async_sync_chain #(
    .WIDTH     (SHORT_N),
    .STAGES    (SHORT_STAGES),
    .RESET_VAL ('1)
  ) short_sync_inst (
    .clk      (clk),
    .rst      (rst),
    .data_in  (short_raw),
    .data_out (short_sync)
  );

  async_sync_chain #(
    .WIDTH     (LONG_N),
    .STAGES    (LONG_STAGES),
    .RESET_VAL (LONG_RST)
  ) long_sync_inst (
    .clk      (clk),
    .rst      (rst),
    .data_in  (long_raw),
    .data_out (long_sync)
  );

  async_sync_chain #(
    .WIDTH     (BUS_N),
    .STAGES    (LONG_STAGES),
    .RESET_VAL ('1)
  ) bus_sync_inst (
    .clk      (clk),
    .rst      (rst),
    .data_in  (bus_raw),
    .data_out (bus_sync)
  );

  for (genvar g = 0; g < 4; g++) begin : g_poll
    capture_bus_poll #(
      .WIDTH     (BUS_W[g]),
      .RESET_VAL ('1)
    ) poll_inst (
      .clk      (clk),
      .rst      (rst),
      .sync_in  (bus_sync[BUS_LSB[g] +: BUS_W[g]]),
      .bypass   (bus_bypass[g]),
      .load     (load),
      .data_out (bus_q[BUS_LSB[g] +: BUS_W[g]])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      short_q <= '1;
      long_q  <= LONG_RST;
    end else if (load) begin
      short_q <= short_sync;
      long_q  <= long_sync;
    end
  end

  always_comb begin
    ssr_data = '0;
    ssr_data[SSR_A1A2_BIT]          = short_q[0];
    ssr_data[SSR_BITLOC_REV_BIT]    = short_q[1];
    ssr_data[SSR_BYTE_REV_BIT]      = short_q[2];
    ssr_data[SSR_ENCDT_BIT]         = short_q[3];
    ssr_data[SSR_KRFEC_CLR_BIT]     = short_q[4];
    ssr_data[SSR_BER_CLR_BIT]       = short_q[5];
    ssr_data[SSR_BITSLIP_BIT]       = short_q[6];
    ssr_data[SSR_POLINV_BIT]        = short_q[7];
    ssr_data[SSR_PRBS_CLR_BIT]      = short_q[8];
    ssr_data[SSR_SYNCSM_EN_BIT]     = short_q[9];
    ssr_data[SSR_LAT_ADJ_BIT]       = short_q[10];
    ssr_data[SSR_ADAPT_START_BIT]   = long_q[0];
    ssr_data[SSR_EARLY_EIOS_BIT]    = long_q[1];
    ssr_data[SSR_PPM_LOCK_BIT]      = long_q[2];
    ssr_data[SSR_RS_LPBK_BIT]       = long_q[3];
    ssr_data[SSR_RXCLKSLIP_BIT]     = long_q[4];
    ssr_data[SSR_DLL_LOCK_BIT]      = long_q[5];
    ssr_data[SSR_DLL_LOCK_REQ_BIT]  = long_q[6];
    ssr_data[SSR_TRANSFER_EN_BIT]   = long_q[7];
    ssr_data[SSR_DCD_CAL_REQ_BIT]   = long_q[8];
    ssr_data[SSR_EIDLEINFERSEL_LSB +: 3] = bus_q[2:0];
    ssr_data[SSR_EYE_MONITOR_LSB +: 6]   = bus_q[8:3];
    ssr_data[SSR_PCIE_SWITCH_LSB +: 2]   = bus_q[10:9];
    ssr_data[SSR_RESERVED_LSB +: 5]      = bus_q[15:11];
  end

  // Single-bit and polled registers together give the documented reset word
  a_reset_word: assert property (@(posedge clk) rst |=> ssr_data == SSR_RESET_VAL);

endmodule
